/* mem_port_pkg.sv */
// shared widths, bus codes and owner states for the memory port unit
// addr_t and tag_t have the default widths; modules sized by their
// addr_width / tag_width parameters use plain vectors of that width
// a zero tag always means "no transaction" or "rejected"
package mem_port_pkg;

    ////////////////////
    // default widths
    ////////////////////
    localparam int ADDR_WIDTH = 32;
    localparam int TAG_WIDTH  = 4;
    localparam int LINE_WIDTH = 64;
    // stores only carry the low word
    localparam int WORD_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [LINE_WIDTH-1:0] line_t;

    ////////////////////
    // bus commands
    ////////////////////
    typedef logic [1:0] cmd_t;
    localparam cmd_t BUS_NONE  = 2'h0;
    localparam cmd_t BUS_LOAD  = 2'h1;
    localparam cmd_t BUS_STORE = 2'h2;

    // access size
    typedef logic [1:0] size_t;
    localparam size_t BYTE   = 2'h0;
    localparam size_t HALF   = 2'h1;
    localparam size_t WORD   = 2'h2;
    localparam size_t DOUBLE = 2'h3;

    // who drove the bus last cycle
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA_LOAD,
        OWN_DATA_STORE
    } owner_e;

endpackage

/* mem_req_if.sv */
// one memory bus request: command, address, write data and size
// command BUS_NONE means the other fields are don't-care
interface mem_req_if #(
    parameter int addr_width = mem_port_pkg::ADDR_WIDTH
);
    import mem_port_pkg::*;

    cmd_t                  command;
    logic [addr_width-1:0] addr;
    line_t                 wdata;
    size_t                 size;

    // side that presents the request
    modport requester (
        output command, addr, wdata, size
    );

    // side that consumes it
    modport bus (
        input command, addr, wdata, size
    );

endinterface

/* bus_owner_ctrl.sv */
// bus arbitration between the data port and the fetch port
// data always wins, fetch only gets the bus when data is idle
// owner_q is the class granted in the previous cycle, so the
// memory's accept response in this cycle belongs to it
module bus_owner_ctrl (
    input  logic                clock,
    input  logic                reset,
    mem_req_if.bus              data_req,
    mem_req_if.bus              fetch_req,
    output mem_port_pkg::owner_e owner_next,
    output mem_port_pkg::owner_e owner_q,
    output logic                fetch_stall
);
    import mem_port_pkg::*;

    logic data_load;
    logic data_store;
    logic fetch_load;

    ////////////////////
    // request decode
    ////////////////////
    // an undefined data command code is treated as no request
    assign data_load  = (data_req.command == BUS_LOAD);
    assign data_store = (data_req.command == BUS_STORE);

    // fetches only ever load
    assign fetch_load = (fetch_req.command == BUS_LOAD);

    // fetch held off whenever the data port asks for the bus
    assign fetch_stall = (data_req.command != BUS_NONE);

    ////////////////////
    // next owner
    ////////////////////
    always_comb begin
        owner_next = OWN_NONE;
        if (data_load) begin
            owner_next = OWN_DATA_LOAD;
        end else if (data_store) begin
            owner_next = OWN_DATA_STORE;
        end else if (fetch_load) begin
            owner_next = OWN_FETCH;
        end
    end

    ////////////////////
    // owner register
    ////////////////////
    // updated every cycle, whether or not memory accepts;
    // a rejected requester retries and simply wins again
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_next;
        end
    end

endmodule

/* bus_request_mux.sv */
// drives the shared memory bus from the winning request
// purely combinational, follows owner_next in the same cycle
// upper 32 bits of write data are always zero
module bus_request_mux #(
    parameter int addr_width = mem_port_pkg::ADDR_WIDTH
) (
    input  mem_port_pkg::owner_e owner_next,
    mem_req_if.bus              data_req,
    mem_req_if.bus              fetch_req,
    mem_req_if.requester        bus_req
);
    import mem_port_pkg::*;

    logic [addr_width-1:0] sel_addr;
    logic [WORD_WIDTH-1:0] sel_word;

    always_comb begin
        bus_req.command = BUS_NONE;
        bus_req.size    = DOUBLE;
        sel_addr        = '0;
        sel_word        = '0;
        case (owner_next)
            OWN_DATA_LOAD, OWN_DATA_STORE: begin
                // data request passes through as given
                bus_req.command = data_req.command;
                bus_req.size    = data_req.size;
                sel_addr        = data_req.addr;
                sel_word        = data_req.wdata[WORD_WIDTH-1:0];
            end
            OWN_FETCH: begin
                // instruction fetch is a double-word load
                bus_req.command = BUS_LOAD;
                bus_req.size    = fetch_req.size;
                sel_addr        = fetch_req.addr;
                sel_word        = fetch_req.wdata[WORD_WIDTH-1:0];
            end
            default: begin
            end
        endcase
    end

    assign bus_req.addr  = sel_addr;
    assign bus_req.wdata = {{(LINE_WIDTH - WORD_WIDTH){1'b0}}, sel_word};

endmodule

/* reply_router.sv */
// steers the memory accept response to last cycle's bus owner
// nonzero response = accepted, zero = rejected (requester retries)
// load tags are forwarded for capture, store accepts carry no tag
module reply_router #(
    parameter int tag_width = mem_port_pkg::TAG_WIDTH
) (
    input  mem_port_pkg::owner_e  owner_q,
    input  logic [tag_width-1:0]  mem2proc_response,
    output logic                  fetch_accept,
    output logic                  data_accept,
    output logic [tag_width-1:0]  fetch_accept_tag,
    output logic [tag_width-1:0]  data_accept_tag
);
    import mem_port_pkg::*;

    logic accepted;
    logic own_data;

    assign accepted = (mem2proc_response != '0);
    assign own_data = (owner_q == OWN_DATA_LOAD) || (owner_q == OWN_DATA_STORE);

    ////////////////////
    // accept pulses
    ////////////////////
    assign fetch_accept = accepted && (owner_q == OWN_FETCH);
    assign data_accept  = accepted && own_data;

    ////////////////////
    // tags for capture
    ////////////////////
    // zero tag means nothing to capture
    assign fetch_accept_tag = fetch_accept ? mem2proc_response : '0;

    // store accept pulses data_accept but leaves the tag at zero
    assign data_accept_tag = (accepted && (owner_q == OWN_DATA_LOAD)) ?
                             mem2proc_response : '0;

endmodule

/* pending_load_tag.sv */
// single outstanding load tag for one port
// captures on capture with a nonzero tag, frees when memory returns it
// done is combinational in the cycle the tag comes back
// a new load while busy overwrites the entry; requesters watch busy
module pending_load_tag #(
    parameter int tag_width = mem_port_pkg::TAG_WIDTH
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 capture,
    input  logic [tag_width-1:0] capture_tag,
    input  logic [tag_width-1:0] mem2proc_tag,
    output logic                 busy,
    output logic                 done
);
    logic                 busy_q;
    logic [tag_width-1:0] tag_q;
    logic                 load_entry;

    // zero tag = store accept or nothing
    assign load_entry = capture && (capture_tag != '0);

    // returned tag matches the one we wait for
    assign done = busy_q && (mem2proc_tag == tag_q);
    assign busy = busy_q;

    ////////////////////
    // entry state
    ////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else if (load_entry) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    // stored tag, only meaningful while busy_q
    always_ff @(posedge clock) begin
        if (load_entry) begin
            tag_q <= capture_tag;
        end
    end

endmodule

/* mem_port_unit.sv */
// memory port unit: fetch port and data port sharing one tagged bus
// protocol: command in t, accept tag (or 0 = reject) in t+1,
// load data later with the matching tag for one cycle
// fetch_data / data_rdata are raw bus data, qualified by the valids
module mem_port_unit #(
    parameter int addr_width = mem_port_pkg::ADDR_WIDTH,
    parameter int tag_width  = mem_port_pkg::TAG_WIDTH
) (
    input  logic                  clock,
    input  logic                  reset,
    // fetch port
    input  logic                  fetch_req,
    input  logic [addr_width-1:0] fetch_addr,
    output logic                  fetch_stall,
    output logic                  fetch_accept,
    output logic                  fetch_busy,
    output logic                  fetch_valid,
    output mem_port_pkg::line_t   fetch_data,
    // data port
    input  mem_port_pkg::cmd_t    data_command,
    input  logic [addr_width-1:0] data_addr,
    input  mem_port_pkg::line_t   data_wdata,
    input  mem_port_pkg::size_t   data_size,
    output logic                  data_accept,
    output logic                  data_busy,
    output logic                  data_valid,
    output mem_port_pkg::line_t   data_rdata,
    // memory side
    input  logic [tag_width-1:0]  mem2proc_response,
    input  logic [tag_width-1:0]  mem2proc_tag,
    input  mem_port_pkg::line_t   mem2proc_data,
    output mem_port_pkg::cmd_t    proc2mem_command,
    output logic [addr_width-1:0] proc2mem_addr,
    output mem_port_pkg::line_t   proc2mem_data,
    output mem_port_pkg::size_t   proc2mem_size
);
    import mem_port_pkg::*;

    owner_e               owner_next;
    owner_e               owner_q;
    logic [tag_width-1:0] fetch_accept_tag;
    logic [tag_width-1:0] data_accept_tag;

    mem_req_if #(.addr_width(addr_width)) data_req_if ();
    mem_req_if #(.addr_width(addr_width)) fetch_req_if ();
    mem_req_if #(.addr_width(addr_width)) bus_req_if ();

    ////////////////////
    // request bundles
    ////////////////////
    assign data_req_if.command = data_command;
    assign data_req_if.addr    = data_addr;
    assign data_req_if.wdata   = data_wdata;
    assign data_req_if.size    = data_size;

    // fetch is always a double-word load
    assign fetch_req_if.command = fetch_req ? BUS_LOAD : BUS_NONE;
    assign fetch_req_if.addr    = fetch_addr;
    assign fetch_req_if.wdata   = '0;
    assign fetch_req_if.size    = DOUBLE;

    bus_owner_ctrl owner_ctrl_i (
        .clock       (clock),
        .reset       (reset),
        .data_req    (data_req_if.bus),
        .fetch_req   (fetch_req_if.bus),
        .owner_next  (owner_next),
        .owner_q     (owner_q),
        .fetch_stall (fetch_stall)
    );

    bus_request_mux #(.addr_width(addr_width)) request_mux_i (
        .owner_next (owner_next),
        .data_req   (data_req_if.bus),
        .fetch_req  (fetch_req_if.bus),
        .bus_req    (bus_req_if.requester)
    );

    reply_router #(.tag_width(tag_width)) reply_router_i (
        .owner_q           (owner_q),
        .mem2proc_response (mem2proc_response),
        .fetch_accept      (fetch_accept),
        .data_accept       (data_accept),
        .fetch_accept_tag  (fetch_accept_tag),
        .data_accept_tag   (data_accept_tag)
    );

    ////////////////////
    // pending loads
    ////////////////////
    pending_load_tag #(.tag_width(tag_width)) fetch_pending_i (
        .clock        (clock),
        .reset        (reset),
        .capture      (fetch_accept),
        .capture_tag  (fetch_accept_tag),
        .mem2proc_tag (mem2proc_tag),
        .busy         (fetch_busy),
        .done         (fetch_valid)
    );

    // store accepts arrive with a zero tag and are not captured
    pending_load_tag #(.tag_width(tag_width)) data_pending_i (
        .clock        (clock),
        .reset        (reset),
        .capture      (data_accept),
        .capture_tag  (data_accept_tag),
        .mem2proc_tag (mem2proc_tag),
        .busy         (data_busy),
        .done         (data_valid)
    );

    // bus outputs
    assign proc2mem_command = bus_req_if.command;
    assign proc2mem_addr    = bus_req_if.addr;
    assign proc2mem_data    = bus_req_if.wdata;
    assign proc2mem_size    = bus_req_if.size;

    assign fetch_data = mem2proc_data;
    assign data_rdata = mem2proc_data;

endmodule

/* tb_mem_port_properties.sv */
// bus protocol properties, bound into the memory port unit
// sampled on the rising clock edge, off during reset
module tb_mem_port_properties #(
    parameter int tag_width = mem_port_pkg::TAG_WIDTH
) (
    input logic                 clock,
    input logic                 reset,
    input logic                 fetch_req,
    input mem_port_pkg::cmd_t   data_command,
    input mem_port_pkg::line_t  data_wdata,
    input logic [tag_width-1:0] mem2proc_response,
    input logic                 fetch_accept, data_accept,
    input logic                 fetch_valid, data_valid,
    input logic                 fetch_busy, data_busy,
    input mem_port_pkg::cmd_t   proc2mem_command,
    input mem_port_pkg::line_t  proc2mem_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_port_pkg::*;

    int accept_fails;
    int valid_fails;
    int wdata_fails;

    // accept only goes to the port that won the bus last cycle
    accept_owner: assert property (@(posedge clock) disable iff (reset)
        (fetch_accept == (mem2proc_response != '0 &&
                          $past(fetch_req && data_command == BUS_NONE))) &&
        (data_accept == (mem2proc_response != '0 && $past(data_command != BUS_NONE))))
        else begin
            accept_fails++;
            $error("accept pulse for a port that did not own the bus");
        end

    // a returned load frees its entry at the next edge
    valid_frees_entry: assert property (@(posedge clock) disable iff (reset)
        (!$past(fetch_valid) || !fetch_busy) && (!$past(data_valid) || !data_busy))
        else begin
            valid_fails++;
            $error("pending entry still busy after its load returned");
        end

    // stores carry the low word only
    store_wdata: assert property (@(posedge clock) disable iff (reset)
        proc2mem_command == BUS_STORE |-> proc2mem_data == {32'h0, data_wdata[31:0]})
        else begin
            wdata_fails++;
            $error("bus write data is not the zero-extended low store word");
        end

endmodule

bind mem_port_unit tb_mem_port_properties #(.tag_width(tag_width)) props_i (.*);

/* tb_mem_port_checker.sv */
// compares the DUT ports with a cycle model of arbitration, accept
// routing and the two pending load entries
// sampled at the rising edge, so every value is the settled value of
// the cycle that just ended
module tb_mem_port_checker (
    input  logic                clock,
    input  logic                reset,
    input  logic                fetch_req,
    input  mem_port_pkg::addr_t fetch_addr, data_addr, proc2mem_addr,
    input  mem_port_pkg::cmd_t  data_command, proc2mem_command,
    input  mem_port_pkg::size_t data_size, proc2mem_size,
    input  mem_port_pkg::line_t data_wdata, fetch_data, data_rdata, proc2mem_data,
    input  mem_port_pkg::tag_t  mem2proc_response, mem2proc_tag,
    input  logic                fetch_stall, fetch_accept, fetch_busy, fetch_valid,
    input  logic                data_accept, data_busy, data_valid,
    output int                  error_count,
    output int                  check_count,
    output int                  loads_seen
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_port_pkg::*;

    // model state
    owner_e last_owner;
    addr_t  last_addr;
    logic   f_busy, d_busy;
    tag_t   f_tag, d_tag;
    addr_t  f_addr, d_addr;

    task automatic compare(input logic ok, input string what);
        check_count++;
        if (!ok) begin
            error_count++;
            $display("ERR %0t: %s", $time, what);
        end
    endtask

    always @(posedge clock) begin
        owner_e cur_owner;
        addr_t  cur_addr;
        logic   accepted;
        logic   f_exp, d_exp;
        if (reset) begin
            last_owner = OWN_NONE;
            last_addr  = '0;
            f_busy     = 1'b0;
            d_busy     = 1'b0;
            error_count = 0;
            check_count = 0;
            loads_seen  = 0;
        end else begin
            ////////////////////
            // bus arbitration
            ////////////////////
            if (data_command != BUS_NONE) begin
                compare(proc2mem_command == data_command && proc2mem_addr == data_addr &&
                        proc2mem_size == data_size,
                        $sformatf("data request not on bus, cmd %0d addr %h",
                                  proc2mem_command, proc2mem_addr));
                compare(proc2mem_data == {32'h0, data_wdata[31:0]},
                        $sformatf("write data %h", proc2mem_data));
                cur_owner = (data_command == BUS_LOAD) ? OWN_DATA_LOAD : OWN_DATA_STORE;
                cur_addr  = data_addr;
            end else if (fetch_req) begin
                compare(proc2mem_command == BUS_LOAD && proc2mem_size == DOUBLE &&
                        proc2mem_addr == fetch_addr,
                        $sformatf("fetch form wrong, cmd %0d size %0d addr %h",
                                  proc2mem_command, proc2mem_size, proc2mem_addr));
                cur_owner = OWN_FETCH;
                cur_addr  = fetch_addr;
            end else begin
                compare(proc2mem_command == BUS_NONE, "command on idle bus");
                cur_owner = OWN_NONE;
                cur_addr  = '0;
            end
            compare(fetch_stall == (data_command != BUS_NONE),
                    $sformatf("fetch_stall %b", fetch_stall));

            // response belongs to last cycle's owner
            accepted = (mem2proc_response != '0);
            compare(fetch_accept == (accepted && last_owner == OWN_FETCH),
                    $sformatf("fetch_accept %b, response %h", fetch_accept, mem2proc_response));
            compare(data_accept == (accepted && (last_owner == OWN_DATA_LOAD ||
                                                 last_owner == OWN_DATA_STORE)),
                    $sformatf("data_accept %b, response %h", data_accept, mem2proc_response));

            ////////////////////
            // pending loads
            ////////////////////
            compare(fetch_busy == f_busy, $sformatf("fetch_busy %b", fetch_busy));
            compare(data_busy == d_busy, $sformatf("data_busy %b", data_busy));
            f_exp = f_busy && (mem2proc_tag == f_tag);
            d_exp = d_busy && (mem2proc_tag == d_tag);
            compare(fetch_valid == f_exp, $sformatf("fetch_valid %b, tag %h", fetch_valid,
                                                   mem2proc_tag));
            compare(data_valid == d_exp, $sformatf("data_valid %b, tag %h", data_valid,
                                                  mem2proc_tag));
            if (f_exp) begin
                compare(fetch_data == {~f_addr, f_addr}, $sformatf("fetch data %h", fetch_data));
                loads_seen++;
                f_busy = 1'b0;
            end
            if (d_exp) begin
                compare(data_rdata == {~d_addr, d_addr}, $sformatf("load data %h", data_rdata));
                loads_seen++;
                d_busy = 1'b0;
            end
            // store accepts leave the entry alone
            if (accepted && last_owner == OWN_FETCH) begin
                f_busy = 1'b1;
                f_tag  = mem2proc_response;
                f_addr = last_addr;
            end
            if (accepted && last_owner == OWN_DATA_LOAD) begin
                d_busy = 1'b1;
                d_tag  = mem2proc_response;
                d_addr = last_addr;
            end
            last_owner = cur_owner;
            last_addr  = cur_addr;
        end
    end

endmodule

/* tb_mem_port.sv */
// testbench top for the memory port unit
// one request in flight per port, retried after a rejection
// memory model answers one cycle after a command and returns load
// data 1 to 4 cycles after acceptance as {~addr, addr}
module tb_mem_port;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_port_pkg::*;

    localparam int TARGET_ACCEPTS = 300;
    localparam int RUN_TIMEOUT    = 5000;
    localparam int DRAIN_TIMEOUT  = 50;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_SHOW,
        REQ_WAIT
    } req_state_e;

    logic  clock;
    logic  reset = 1'b1;
    logic  fetch_req = 1'b0;
    addr_t fetch_addr = '0;
    cmd_t  data_command = BUS_NONE;
    addr_t data_addr = '0;
    line_t data_wdata = '0;
    size_t data_size = BYTE;
    tag_t  mem2proc_response = '0;
    tag_t  mem2proc_tag = '0;
    line_t mem2proc_data = '0;
    logic  fetch_stall, fetch_accept, fetch_busy, fetch_valid;
    logic  data_accept, data_busy, data_valid;
    line_t fetch_data, data_rdata, proc2mem_data;
    cmd_t  proc2mem_command;
    addr_t proc2mem_addr;
    size_t proc2mem_size;
    int    error_count, check_count, loads_seen;

    // requester state, one per port
    req_state_e fetch_state = REQ_IDLE;
    req_state_e data_state = REQ_IDLE;
    cmd_t       data_saved = BUS_NONE;
    int         fetch_accepts = 0;
    int         data_accepts = 0;
    logic       issue_enable = 1'b0;

    // return pipeline of the memory model, slot 1 comes out next
    tag_t  ret_tag [1:4];
    line_t ret_data [1:4];
    tag_t  next_tag;

    mem_port_unit dut_i (.*);
    tb_mem_port_checker checker_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // both requesters quiet and no load outstanding
    function automatic logic ports_idle();
        return fetch_state == REQ_IDLE && data_state == REQ_IDLE && !fetch_busy && !data_busy;
    endfunction

    ////////////////////
    // run control
    ////////////////////
    initial begin
        int   cycles;
        int   fails;
        logic timed_out;
        void'($urandom(32'h5402_7192));
        timed_out = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        issue_enable <= 1'b1;
        cycles = 0;
        while ((fetch_accepts + data_accepts) < TARGET_ACCEPTS && cycles < RUN_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if ((fetch_accepts + data_accepts) < TARGET_ACCEPTS) begin
            $display("timeout: only %0d requests accepted in %0d cycles",
                     fetch_accepts + data_accepts, cycles);
            timed_out = 1'b1;
        end else begin
            // stop issuing, let pending loads come back
            issue_enable <= 1'b0;
            cycles = 0;
            do begin
                @(negedge clock);
                cycles++;
            end while (!ports_idle() && cycles < DRAIN_TIMEOUT);
            if (!ports_idle()) begin
                $display("timeout: ports still busy %0d cycles after the last request",
                         cycles);
                timed_out = 1'b1;
            end
        end
        // counters settle between edges
        @(negedge clock);
        fails = dut_i.props_i.accept_fails + dut_i.props_i.valid_fails +
                dut_i.props_i.wdata_fails;
        $display("summary: %0d accepts, %0d loads, %0d checks, %0d errors, %0d assert fails",
                 fetch_accepts + data_accepts, loads_seen, check_count, error_count, fails);
        if (timed_out || error_count != 0 || fails != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

    ////////////////////
    // fetch requester
    ////////////////////
    always @(posedge clock) begin
        logic [31:0] r;
        if (!reset) begin
            r = $urandom;
            case (fetch_state)
                REQ_IDLE: begin
                    if (issue_enable && !fetch_busy && r[0]) begin
                        fetch_req   <= 1'b1;
                        fetch_addr  <= {r[31:3], 3'b000};
                        fetch_state <= REQ_SHOW;
                    end
                end
                // held off while the data port owns the bus
                REQ_SHOW: begin
                    if (!fetch_stall) begin
                        fetch_req   <= 1'b0;
                        fetch_state <= REQ_WAIT;
                    end
                end
                default: begin
                    if (fetch_accept) begin
                        fetch_accepts <= fetch_accepts + 1;
                        fetch_state   <= REQ_IDLE;
                    end else begin
                        // rejected, same address again
                        fetch_req   <= 1'b1;
                        fetch_state <= REQ_SHOW;
                    end
                end
            endcase
        end
    end

    ////////////////////
    // data requester
    ////////////////////
    always @(posedge clock) begin
        logic [31:0] r;
        cmd_t        c;
        if (!reset) begin
            r = $urandom;
            case (data_state)
                REQ_IDLE: begin
                    if (issue_enable && r[0]) begin
                        // new load only with a free pending entry
                        c = (r[1] && !data_busy) ? BUS_LOAD : BUS_STORE;
                        data_command <= c;
                        data_saved   <= c;
                        data_size    <= r[3:2];
                        data_addr    <= $urandom;
                        data_wdata   <= {$urandom, $urandom};
                        data_state   <= REQ_SHOW;
                    end
                end
                // data always wins, so it was on the bus
                REQ_SHOW: begin
                    data_command <= BUS_NONE;
                    data_state   <= REQ_WAIT;
                end
                default: begin
                    if (data_accept) begin
                        data_accepts <= data_accepts + 1;
                        data_state   <= REQ_IDLE;
                    end else begin
                        data_command <= data_saved;
                        data_state   <= REQ_SHOW;
                    end
                end
            endcase
        end
    end

    ////////////////////
    // memory model
    ////////////////////
    always @(posedge clock) begin
        int d;
        if (reset) begin
            for (int i = 1; i <= 4; i++) begin
                ret_tag[i]  = '0;
                ret_data[i] = '0;
            end
            next_tag = 4'd1;
            mem2proc_response <= '0;
            mem2proc_tag      <= '0;
            mem2proc_data     <= '0;
        end else begin
            mem2proc_tag  <= ret_tag[1];
            // garbage on the data lines when nothing returns
            mem2proc_data <= (ret_tag[1] != '0) ? ret_data[1] : {$urandom, $urandom};
            for (int i = 1; i < 4; i++) begin
                ret_tag[i]  = ret_tag[i + 1];
                ret_data[i] = ret_data[i + 1];
            end
            ret_tag[4] = '0;
            mem2proc_response <= '0;
            // one in four commands rejected
            if (proc2mem_command != BUS_NONE && ($urandom % 4) != 0) begin
                mem2proc_response <= next_tag;
                if (proc2mem_command == BUS_LOAD) begin
                    // at most one other load in flight, so a free slot exists
                    d = 1 + ($urandom % 4);
                    if (ret_tag[d] != '0) begin
                        d = (d % 4) + 1;
                    end
                    ret_tag[d]  = next_tag;
                    ret_data[d] = {~proc2mem_addr, proc2mem_addr};
                end
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    end

endmodule

/* verilog.f */
mem_port_pkg.sv
mem_req_if.sv
bus_owner_ctrl.sv
bus_request_mux.sv
reply_router.sv
pending_load_tag.sv
mem_port_unit.sv
tb_mem_port_properties.sv
tb_mem_port_checker.sv
tb_mem_port.sv

/* Makefile */
TOP := tb_mem_port
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f verilog.f --top-module mem_port_unit
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
